//--- suprloco_video.f
common/suprloco_pkg.sv
source/video_timing.sv
tilemap/tile_write_buffer.sv
tilemap/tilemap_fetch.sv
tilemap/tile_shifter.sv
source/palette_out.sv
source/suprloco_video.sv
dv/suprloco_video_tb.sv

//--- common/tile_pattern.hex
// one row per line {plane2, plane1, plane0}, 8 rows per tile, bit 7 is the leftmost dot
0F33C3
1E66A5
3CCC5A
78993C
F03366
E166C3
C3CC99
87990F
FF00AA
7F8055
3FC0AA
1FE055
0FF0AA
07F855
03FCAA
01FE55
18243C
2442C3
4281FF
81FF18
FF1824
24C342
C33C81
3C18E7
AA55F0
55AA0F
CC33F0
33CC0F
F00FAA
0FF055
99665A
6699A5
0102FE
0204FD
0408FB
0810F7
1020EF
2040DF
4080BF
80017F
E3711C
C7E238
8FC471
1F88E3
3E11C7
7C238F
F8471E
F18E3C
5A3CFF
A5C300
5A3C81
A5C3C3
5A3CE7
A5C3FF
5A3C7E
A5C33C
6CB2D9
D9656C
B2CA36
65949B
CA29CD
9453E6
29A773
534E39

//--- common/palette.hex
// 3-3-2 color word per entry, address is {palette code, tile pixel}
07
38
C0
3F
F8
C7
FF
52
11
2A
49
64
8B
A6
D3
E4
1C
23
45
6E
92
B7
D9
FE
05
0E
36
5B
7D
9A
BC
F1

//--- dv/suprloco_video_tb.sv
`default_nettype none

module suprloco_video_tb;

    localparam int WR_CREDITS     = 2;
    localparam int PATTERN_TILES  = 8;
    localparam int NUM_TESTS      = 10;
    localparam int FRAME_CYCLES   = int'(suprloco_pkg::H_TOTAL) *
                                    int'(suprloco_pkg::V_TOTAL) * 8;
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 16 + 4096;

    logic                      clk40m;
    logic                      mrst_n;
    logic                      wr_valid;
    suprloco_pkg::tmram_addr_t wr_addr;
    suprloco_pkg::byte_t       wr_data;
    logic                      wr_credit;
    logic                      video_en;
    suprloco_pkg::rgb_t        video_rgb;
    logic                      hsync_n;
    logic                      vsync_n;

    // reference model state
    logic [23:0] pattern_rom [PATTERN_TILES*8];
    logic [7:0]  palette_rom [32];
    logic [7:0]  shadow [2048];
    string       tile_name [896];
    logic [10:0] wq_addr [$];
    logic [7:0]  wq_data [$];

    // stimulus table
    string t_name [NUM_TESTS];
    int    t_row [NUM_TESTS];
    int    t_col [NUM_TESTS];
    int    t_code [NUM_TESTS];
    int    t_pal [NUM_TESTS];
    int    t_scroll [NUM_TESTS];

    int   cycle = 0;
    int   reset_errors = 0;
    int   credit_errors = 0;
    int   frame_errors = 0;
    int   pixel_errors = 0;
    int   timeout_errors = 0;
    int   credits = WR_CREDITS;
    int   sent = 0;
    int   returned = 0;
    int   dot_clk = 0;
    int   line_dots = 0;
    int   sync_dots = 0;
    int   frame_lines = 0;
    int   frames_checked = 0;
    int   pixels_checked = 0;
    logic dot_known = 1'b0;
    logic prev_en = 1'b0;
    logic prev_vsync_n = 1'b1;
    logic check_pixels = 1'b0;
    logic writes_done = 1'b0;

    suprloco_video #(
        .WR_CREDITS    (WR_CREDITS),
        .PATTERN_TILES (PATTERN_TILES)
    ) suprloco_video_inst (
        .i_clk40m    (clk40m),
        .i_mrst_n    (mrst_n),
        .i_wr_valid  (wr_valid),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .o_wr_credit (wr_credit),
        .o_video_en  (video_en),
        .o_video_rgb (video_rgb),
        .o_hsync_n   (hsync_n),
        .o_vsync_n   (vsync_n)
    );

    initial begin
        clk40m = 1'b0;
        forever #5 clk40m = ~clk40m;
    end

    //////////////////////////////////////////////////////////////////////
    // table and tile RAM image
    task automatic set_entry(input int idx, input string name, input int row, input int col,
                             input int code, input int pal, input int scroll);
        t_name[idx]   = name;
        t_row[idx]    = row;
        t_col[idx]    = col;
        t_code[idx]   = code;
        t_pal[idx]    = pal;
        t_scroll[idx] = scroll;
    endtask

    task automatic build_model;
        int    k;
        int    base;
        logic [31:0] rnd;
        set_entry(0, "origin_tile", 0, 0, 8'h01, 0, 0);
        set_entry(1, "right_edge", 2, 31, 8'h06, 1, 0);
        set_entry(2, "bank_0", 5, 10, 8'h03, 0, 0);
        set_entry(3, "bank_1", 5, 11, 8'h03, 1, 0);
        set_entry(4, "bank_2", 5, 12, 8'h03, 2, 0);
        set_entry(5, "bank_3", 5, 13, 8'h03, 3, 0);
        set_entry(6, "fine_scroll", 9, 4, 8'h05, 2, 8'h03);
        set_entry(7, "coarse_scroll", 14, 20, 8'h02, 3, 8'h48);
        set_entry(8, "scroll_wrap", 27, 0, 8'h07, 1, 8'hF5);
        set_entry(9, "code_upper_bits", 20, 15, 8'hA4, 0, 0);
        for (k = 0; k < 2048; k++) begin
            shadow[k] = 8'h00;
        end
        // filler tiles everywhere with random code and attribute
        for (k = 0; k < 896; k++) begin
            tile_name[k] = "filler";
            rnd = $urandom;
            shadow[2 * k] = rnd[7:0];
            shadow[2 * k + 1] = rnd[15:8];
        end
        for (k = 0; k < NUM_TESTS; k++) begin
            base = t_row[k] * 64 + t_col[k] * 2;
            shadow[base] = t_code[k][7:0];
            shadow[base + 1] = {3'b000, t_pal[k][1:0], 3'b000};
            shadow[suprloco_pkg::SCROLL_BASE + t_row[k]] = t_scroll[k][7:0];
            tile_name[t_row[k] * 32 + t_col[k]] = t_name[k];
        end
        // scroll bytes go first and every tile entry after them
        for (k = 0; k < 28; k++) begin
            wq_addr.push_back(suprloco_pkg::SCROLL_BASE + k);
            wq_data.push_back(shadow[suprloco_pkg::SCROLL_BASE + k]);
        end
        for (k = 0; k < 28 * 64; k++) begin
            wq_addr.push_back(k);
            wq_data.push_back(shadow[k]);
        end
    endtask

    // screen x shows map x + scroll of its tile row
    function automatic logic [7:0] model_rgb(input int x, input int y);
        int          row;
        int          mx;
        int          base;
        int          bitpos;
        logic [7:0]  attr;
        logic [23:0] planes;
        logic [4:0]  idx;
        row = y / 8;
        mx = (x + int'(shadow[suprloco_pkg::SCROLL_BASE + row])) % 256;
        base = row * 64 + (mx / 8) * 2;
        attr = shadow[base + 1];
        planes = pattern_rom[(int'(shadow[base]) % PATTERN_TILES) * 8 + y % 8];
        bitpos = 7 - mx % 8;
        idx = {attr[4:3], planes[16 + bitpos], planes[8 + bitpos], planes[bitpos]};
        return palette_rom[idx];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // host side with credits counted once per clock
    task automatic step_host(input logic send, input suprloco_pkg::tmram_addr_t addr,
                             input suprloco_pkg::byte_t data);
        @(posedge clk40m);
        #1;
        if (wr_credit) begin
            assert (returned < sent) else begin
                credit_errors++;
                $display("credit pulse arrived with no write outstanding");
            end
            returned++;
            credits++;
        end
        if (send) begin
            credits--;
            sent++;
        end
        wr_valid = send;
        wr_addr  = addr;
        wr_data  = data;
    endtask

    //////////////////////////////////////////////////////////////////////
    // output monitor
    task automatic check_idle;
        assert (video_en === 1'b0 && wr_credit === 1'b0 && hsync_n === 1'b1 &&
                vsync_n === 1'b1 && video_rgb === 8'h00) else begin
            reset_errors++;
            $display("outputs not idle during or right after reset at cycle %0d", cycle);
        end
    endtask

    task automatic check_pixel(input int x, input int y);
        logic [7:0] exp_rgb;
        int         mx;
        mx = (x + int'(shadow[suprloco_pkg::SCROLL_BASE + y / 8])) % 256;
        exp_rgb = model_rgb(x, y);
        pixels_checked++;
        assert (video_rgb === exp_rgb) else begin
            pixel_errors++;
            $display("error %s: x=%0d y=%0d expected %02h actual %02h",
                     tile_name[(y / 8) * 32 + mx / 8], x, y, exp_rgb, video_rgb);
        end
    endtask

    task automatic close_frame;
        assert (frame_lines == suprloco_pkg::V_ACTIVE) else begin
            frame_errors++;
            $display("error frame_lines: expected %0d actual %0d",
                     suprloco_pkg::V_ACTIVE, frame_lines);
        end
        frame_lines = 0;
        if (check_pixels) begin
            frames_checked++;
        end
        if (writes_done) begin
            check_pixels = 1'b1;
        end
    endtask

    task automatic sample_dot;
        if (prev_vsync_n && !vsync_n) begin
            close_frame();
        end
        if (!hsync_n) begin
            sync_dots++;
        end
        if (video_en) begin
            // each gap between visible lines holds one hsync pulse
            if (!prev_en && frame_lines > 0) begin
                assert (sync_dots == suprloco_pkg::H_SYNC_LEN) else begin
                    frame_errors++;
                    $display("error hsync_width: expected %0d actual %0d",
                             suprloco_pkg::H_SYNC_LEN, sync_dots);
                end
            end
            if (check_pixels && line_dots < 256 && frame_lines < 224) begin
                check_pixel(line_dots, frame_lines);
            end
            line_dots++;
        end else begin
            if (prev_en) begin
                assert (line_dots == suprloco_pkg::H_ACTIVE) else begin
                    frame_errors++;
                    $display("error line_dots: expected %0d actual %0d",
                             suprloco_pkg::H_ACTIVE, line_dots);
                end
                frame_lines++;
                line_dots = 0;
                sync_dots = 0;
            end
            assert (video_rgb === 8'h00) else begin
                pixel_errors++;
                $display("error blanking: expected 00 actual %02h", video_rgb);
            end
        end
        prev_en = video_en;
        prev_vsync_n = vsync_n;
    endtask

    always @(negedge clk40m) begin
        if (cycle >= 1 && cycle <= 24) begin
            check_idle();
        end
        if (mrst_n) begin
            if (dot_known) begin
                dot_clk = (dot_clk + 1) % 8;
                if (dot_clk == 0) begin
                    sample_dot();
                end
            end else if (video_en === 1'b1) begin
                // outputs move on dot edges and the first visible dot fixes the phase
                dot_known = 1'b1;
                dot_clk = 0;
                sample_dot();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // end of run
    task automatic finish_run;
        int total;
        total = reset_errors + credit_errors + frame_errors + pixel_errors + timeout_errors;
        $display("errors: reset=%0d credit=%0d frame=%0d pixel=%0d timeout=%0d",
                 reset_errors, credit_errors, frame_errors, pixel_errors, timeout_errors);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    always @(posedge clk40m) begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES) begin
            timeout_errors++;
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run();
        end
    end

    initial begin
        int seed_draw;
        int i;
        int waited;
        seed_draw = $urandom(65);
        mrst_n   = 1'b0;
        wr_valid = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        $readmemh("common/tile_pattern.hex", pattern_rom);
        $readmemh("common/palette.hex", palette_rom);
        build_model();
        repeat (16) @(posedge clk40m);
        #1;
        mrst_n = 1'b1;

        // burst of one write per starting credit
        for (i = 0; i < WR_CREDITS; i++) begin
            step_host(1'b1, wq_addr[i], wq_data[i]);
        end
        waited = 0;
        while (returned < WR_CREDITS) begin
            step_host(1'b0, '0, '0);
            waited++;
        end
        assert (waited <= WR_CREDITS * 64) else begin
            credit_errors++;
            $display("error burst_latency: expected <= %0d actual %0d", WR_CREDITS * 64, waited);
        end
        repeat (128) step_host(1'b0, '0, '0);
        assert (returned == WR_CREDITS) else begin
            credit_errors++;
            $display("error burst_credits: expected %0d actual %0d", WR_CREDITS, returned);
        end

        // rest of the image paced by credits
        i = WR_CREDITS;
        while (i < wq_addr.size() || returned < sent) begin
            if (i < wq_addr.size() && credits > 0) begin
                step_host(1'b1, wq_addr[i], wq_data[i]);
                i++;
            end else begin
                step_host(1'b0, '0, '0);
            end
        end
        assert (credits == WR_CREDITS) else begin
            credit_errors++;
            $display("error credit_total: expected %0d actual %0d", WR_CREDITS, credits);
        end
        writes_done = 1'b1;

        wait (frames_checked == 2);
        assert (pixels_checked == 2 * 256 * 224) else begin
            frame_errors++;
            $display("error pixel_count: expected %0d actual %0d", 2 * 256 * 224, pixels_checked);
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- source/suprloco_video.sv
`default_nettype none

module suprloco_video #(
    parameter int WR_CREDITS    = 2,
    parameter int PATTERN_TILES = 8
) (
    input  logic                      i_clk40m,
    input  logic                      i_mrst_n,
    input  logic                      i_wr_valid,
    input  suprloco_pkg::tmram_addr_t i_wr_addr,
    input  suprloco_pkg::byte_t       i_wr_data,
    output logic                      o_wr_credit,
    output logic                      o_video_en,
    output suprloco_pkg::rgb_t        o_video_rgb,
    output logic                      o_hsync_n,
    output logic                      o_vsync_n
);

    logic                      dot_en;
    suprloco_pkg::h_count_t    h_count;
    suprloco_pkg::v_count_t    v_count;
    logic                      active;
    logic                      wb_pending;
    suprloco_pkg::tmram_addr_t wb_addr;
    suprloco_pkg::byte_t       wb_data;
    logic                      wb_take;
    suprloco_pkg::byte_t       tile_code;
    suprloco_pkg::pal_code_t   pal_code;
    logic                      load;
    suprloco_pkg::pixel_t      fine;
    suprloco_pkg::pal_index_t  pal_index;

    video_timing video_timing_inst (
        .i_clk40m  (i_clk40m),
        .i_mrst_n  (i_mrst_n),
        .o_dot_en  (dot_en),
        .o_h_count (h_count),
        .o_v_count (v_count),
        .o_active  (active),
        .o_hsync_n (o_hsync_n),
        .o_vsync_n (o_vsync_n)
    );

    tile_write_buffer #(.WR_CREDITS(WR_CREDITS)) tile_write_buffer_inst (
        .i_clk40m    (i_clk40m),
        .i_mrst_n    (i_mrst_n),
        .i_wr_valid  (i_wr_valid),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .i_take      (wb_take),
        .o_pending   (wb_pending),
        .o_addr      (wb_addr),
        .o_data      (wb_data),
        .o_wr_credit (o_wr_credit)
    );

    tilemap_fetch tilemap_fetch_inst (
        .i_clk40m    (i_clk40m),
        .i_mrst_n    (i_mrst_n),
        .i_dot_en    (dot_en),
        .i_h_count   (h_count),
        .i_v_count   (v_count),
        .i_pending   (wb_pending),
        .i_wb_addr   (wb_addr),
        .i_wb_data   (wb_data),
        .o_take      (wb_take),
        .o_tile_code (tile_code),
        .o_pal_code  (pal_code),
        .o_load      (load),
        .o_fine      (fine)
    );

    tile_shifter #(.PATTERN_TILES(PATTERN_TILES)) tile_shifter_inst (
        .i_clk40m      (i_clk40m),
        .i_mrst_n      (i_mrst_n),
        .i_dot_en      (dot_en),
        .i_tile_code   (tile_code),
        .i_pattern_row (v_count[2:0]),
        .i_pal_code    (pal_code),
        .i_load        (load),
        .i_fine        (fine),
        .o_pal_index   (pal_index)
    );

    palette_out palette_out_inst (
        .i_clk40m    (i_clk40m),
        .i_mrst_n    (i_mrst_n),
        .i_dot_en    (dot_en),
        .i_pal_index (pal_index),
        .i_active    (active),
        .o_video_en  (o_video_en),
        .o_video_rgb (o_video_rgb)
    );

endmodule

`default_nettype wire

//--- source/palette_out.sv
`default_nettype none

module palette_out (
    input  logic                     i_clk40m,
    input  logic                     i_mrst_n,
    input  logic                     i_dot_en,
    input  suprloco_pkg::pal_index_t i_pal_index,
    input  logic                     i_active,
    output logic                     o_video_en,
    output suprloco_pkg::rgb_t       o_video_rgb
);

    suprloco_pkg::rgb_t pal_rom [32];
    suprloco_pkg::rgb_t pal_rgb;
    logic [suprloco_pkg::PIPE_DOTS-1:0] act_d;
    logic               blank_q;

    initial begin
        $readmemh("common/palette.hex", pal_rom);
    end

    // palette lookup, one dot
    always_ff @(posedge i_clk40m) begin
        if (i_dot_en) begin
            pal_rgb <= pal_rom[i_pal_index];
        end
    end

    // active flag follows the pixel path, the whole pipe in dots
    always_ff @(posedge i_clk40m) begin
        if (!i_mrst_n) begin
            act_d       <= '0;
            blank_q     <= 1'b1;
            o_video_rgb <= '0;
        end else if (i_dot_en) begin
            act_d       <= {act_d[suprloco_pkg::PIPE_DOTS-2:0], i_active};
            blank_q     <= !act_d[suprloco_pkg::PIPE_DOTS-3];
            o_video_rgb <= blank_q ? 8'h00 : pal_rgb;
        end
    end

    assign o_video_en = act_d[suprloco_pkg::PIPE_DOTS-1];

endmodule

`default_nettype wire

//--- tilemap/tile_shifter.sv
`default_nettype none

module tile_shifter #(
    parameter int PATTERN_TILES = 8
) (
    input  logic                     i_clk40m,
    input  logic                     i_mrst_n,
    input  logic                     i_dot_en,
    input  suprloco_pkg::byte_t      i_tile_code,
    input  suprloco_pkg::pixel_t     i_pattern_row,
    input  suprloco_pkg::pal_code_t  i_pal_code,
    input  logic                     i_load,
    input  suprloco_pkg::pixel_t     i_fine,
    output suprloco_pkg::pal_index_t o_pal_index
);

    localparam int TW = $clog2(PATTERN_TILES);

    // {plane2, plane1, plane0} per tile row
    logic [23:0]             pat_rom [PATTERN_TILES*8];
    logic [TW+2:0]           pat_idx;
    logic [23:0]             hold_planes;
    suprloco_pkg::pal_code_t hold_pal;
    suprloco_pkg::pal_code_t pal_q;
    logic [7:0]              sr_a;
    logic [7:0]              sr_b;
    logic [7:0]              sr_c;
    logic [2:0]              phase;

    initial begin
        $readmemh("common/tile_pattern.hex", pat_rom);
    end

    assign pat_idx = {i_tile_code[TW-1:0], i_pattern_row};

    // dots since the last hand-over
    always_ff @(posedge i_clk40m) begin
        if (!i_mrst_n) begin
            phase <= '0;
        end else if (i_dot_en) begin
            phase <= i_load ? 3'd0 : phase + 3'd1;
        end
    end

    always_ff @(posedge i_clk40m) begin
        if (i_dot_en) begin
            if (i_load) begin
                hold_planes <= pat_rom[pat_idx];
                hold_pal    <= i_pal_code;
            end
            // fine scroll moves the parallel load, 7 - fine dots late
            if (phase == ~i_fine) begin
                sr_a  <= hold_planes[7:0];
                sr_b  <= hold_planes[15:8];
                sr_c  <= hold_planes[23:16];
                pal_q <= hold_pal;
            end else begin
                sr_a <= {sr_a[6:0], 1'b0};
                sr_b <= {sr_b[6:0], 1'b0};
                sr_c <= {sr_c[6:0], 1'b0};
            end
        end
    end

    // leftmost pixel first
    assign o_pal_index = {pal_q, sr_c[7], sr_b[7], sr_a[7]};

endmodule

`default_nettype wire

//--- tilemap/tilemap_fetch.sv
`default_nettype none

module tilemap_fetch (
    input  logic                      i_clk40m,
    input  logic                      i_mrst_n,
    input  logic                      i_dot_en,
    input  suprloco_pkg::h_count_t    i_h_count,
    input  suprloco_pkg::v_count_t    i_v_count,
    input  logic                      i_pending,
    input  suprloco_pkg::tmram_addr_t i_wb_addr,
    input  suprloco_pkg::byte_t       i_wb_data,
    output logic                      o_take,
    output suprloco_pkg::byte_t       o_tile_code,
    output suprloco_pkg::pal_code_t   o_pal_code,
    output logic                      o_load,
    output suprloco_pkg::pixel_t      o_fine
);

    suprloco_pkg::byte_t       tmram [2048];
    suprloco_pkg::byte_t       ram_q;
    suprloco_pkg::byte_t       scroll_q;
    suprloco_pkg::byte_t       code_hi_q;
    suprloco_pkg::fetch_state_t state;
    suprloco_pkg::fetch_state_t last_state;
    suprloco_pkg::tmram_addr_t ram_addr;
    suprloco_pkg::v_count_t    next_v;
    logic [4:0]                tile_col;

    //////////////////////////////////////////////////////////////////////
    // slot sequence within each 8-dot group
    always_comb begin
        case (i_h_count[2:0])
            3'd0:    state = (i_h_count == suprloco_pkg::SCROLL_FETCH_H) ?
                             suprloco_pkg::FETCH_SCROLL : suprloco_pkg::FETCH_IDLE;
            3'd1:    state = suprloco_pkg::FETCH_CODE_LO;
            3'd2:    state = suprloco_pkg::FETCH_CODE_HI;
            3'd3:    state = suprloco_pkg::FETCH_HOST_WRITE;
            default: state = suprloco_pkg::FETCH_IDLE;
        endcase
    end

    // scroll is read in blanking for the line that follows
    assign next_v   = (i_v_count == suprloco_pkg::V_TOTAL - 9'd1) ? 9'd0 : i_v_count + 9'd1;
    assign tile_col = i_h_count[7:3] + scroll_q[7:3];

    always_comb begin
        case (state)
            suprloco_pkg::FETCH_SCROLL:     ram_addr = suprloco_pkg::SCROLL_BASE + 11'(next_v[7:3]);
            suprloco_pkg::FETCH_CODE_HI:    ram_addr = {i_v_count[7:3], tile_col, 1'b1};
            suprloco_pkg::FETCH_HOST_WRITE: ram_addr = i_wb_addr;
            default:                        ram_addr = {i_v_count[7:3], tile_col, 1'b0};
        endcase
    end

    // single port, host data lands only in its own slot
    always_ff @(posedge i_clk40m) begin
        if (i_dot_en) begin
            if (o_take) begin
                tmram[ram_addr] <= i_wb_data;
            end
            ram_q <= tmram[ram_addr];
        end
    end

    assign o_take = i_dot_en && (state == suprloco_pkg::FETCH_HOST_WRITE) && i_pending;

    //////////////////////////////////////////////////////////////////////
    // latches fill one dot after their read
    always_ff @(posedge i_clk40m) begin
        if (!i_mrst_n) begin
            last_state <= suprloco_pkg::FETCH_IDLE;
            scroll_q   <= '0;
        end else if (i_dot_en) begin
            last_state <= state;
            if (last_state == suprloco_pkg::FETCH_SCROLL) begin
                scroll_q <= ram_q;
            end
        end
    end

    always_ff @(posedge i_clk40m) begin
        if (i_dot_en) begin
            if (last_state == suprloco_pkg::FETCH_CODE_LO) begin
                o_tile_code <= ram_q;
            end
            if (last_state == suprloco_pkg::FETCH_CODE_HI) begin
                code_hi_q <= ram_q;
            end
        end
    end

    // hand over at phase 5, the shifter picks the exact dot from fine
    assign o_load     = i_dot_en && (i_h_count[2:0] == 3'd5);
    assign o_pal_code = code_hi_q[4:3];
    assign o_fine     = scroll_q[2:0];

endmodule

`default_nettype wire

//--- tilemap/tile_write_buffer.sv
`default_nettype none

module tile_write_buffer #(
    parameter int WR_CREDITS = 2
) (
    input  logic                      i_clk40m,
    input  logic                      i_mrst_n,
    input  logic                      i_wr_valid,
    input  suprloco_pkg::tmram_addr_t i_wr_addr,
    input  suprloco_pkg::byte_t       i_wr_data,
    input  logic                      i_take,
    output logic                      o_pending,
    output suprloco_pkg::tmram_addr_t o_addr,
    output suprloco_pkg::byte_t       o_data,
    output logic                      o_wr_credit
);

    localparam int AW = (WR_CREDITS > 1) ? $clog2(WR_CREDITS) : 1;

    suprloco_pkg::tmram_addr_t addr_mem [WR_CREDITS];
    suprloco_pkg::byte_t       data_mem [WR_CREDITS];
    logic [AW-1:0]             wr_ptr;
    logic [AW-1:0]             rd_ptr;
    logic [AW:0]               count;
    logic                      full;

    assign full      = (count == (AW + 1)'(WR_CREDITS));
    assign o_pending = (count != '0);
    assign o_addr    = addr_mem[rd_ptr];
    assign o_data    = data_mem[rd_ptr];

    always_ff @(posedge i_clk40m) begin
        if (i_wr_valid) begin
            addr_mem[wr_ptr] <= i_wr_addr;
            data_mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk40m) begin
        if (!i_mrst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            o_wr_credit <= 1'b0;
        end else begin
            if (i_wr_valid) begin
                wr_ptr <= (wr_ptr == AW'(WR_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_take) begin
                rd_ptr <= (rd_ptr == AW'(WR_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_wr_valid, i_take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per entry written to tile RAM
            o_wr_credit <= i_take;
        end
    end

    // host spends credits, so it never finds the buffer full
    a_no_overflow: assert property (@(posedge i_clk40m) disable iff (!i_mrst_n)
        i_wr_valid |-> !full);

endmodule

`default_nettype wire

//--- source/video_timing.sv
`default_nettype none

module video_timing (
    input  logic                   i_clk40m,
    input  logic                   i_mrst_n,
    output logic                   o_dot_en,
    output suprloco_pkg::h_count_t o_h_count,
    output suprloco_pkg::v_count_t o_v_count,
    output logic                   o_active,
    output logic                   o_hsync_n,
    output logic                   o_vsync_n
);

    logic [2:0] prescaler;
    logic       h_wrap;
    logic       in_hsync;
    logic       in_vsync;

    //////////////////////////////////////////////////////////////////////
    // prescaler, 40 MHz down to the 5 MHz dot enable
    always_ff @(posedge i_clk40m) begin
        if (!i_mrst_n) begin
            prescaler <= '0;
        end else begin
            prescaler <= (prescaler == suprloco_pkg::PRESCALE_LAST) ? 3'd0 : prescaler + 3'd1;
        end
    end

    assign o_dot_en = (prescaler == suprloco_pkg::PRESCALE_LAST);

    //////////////////////////////////////////////////////////////////////
    // h/v counters
    assign h_wrap = (o_h_count == suprloco_pkg::H_TOTAL - 9'd1);

    always_ff @(posedge i_clk40m) begin
        if (!i_mrst_n) begin
            o_h_count <= '0;
            o_v_count <= '0;
        end else if (o_dot_en) begin
            o_h_count <= h_wrap ? 9'd0 : o_h_count + 9'd1;
            if (h_wrap) begin
                o_v_count <= (o_v_count == suprloco_pkg::V_TOTAL - 9'd1) ? 9'd0 : o_v_count + 9'd1;
            end
        end
    end

    assign o_active = (o_h_count < suprloco_pkg::H_ACTIVE) && (o_v_count < suprloco_pkg::V_ACTIVE);

    assign in_hsync = (o_h_count >= suprloco_pkg::H_SYNC_START) &&
                      (o_h_count < suprloco_pkg::H_SYNC_START + suprloco_pkg::H_SYNC_LEN);
    assign in_vsync = (o_v_count >= suprloco_pkg::V_SYNC_START) &&
                      (o_v_count < suprloco_pkg::V_SYNC_START + suprloco_pkg::V_SYNC_LEN);

    // sync lags the counters by one dot
    always_ff @(posedge i_clk40m) begin
        if (!i_mrst_n) begin
            o_hsync_n <= 1'b1;
            o_vsync_n <= 1'b1;
        end else if (o_dot_en) begin
            o_hsync_n <= !in_hsync;
            o_vsync_n <= !in_vsync;
        end
    end

    // counters never leave the frame
    a_count_range: assert property (@(posedge i_clk40m) disable iff (!i_mrst_n)
        (o_h_count < suprloco_pkg::H_TOTAL) && (o_v_count < suprloco_pkg::V_TOTAL));

endmodule

`default_nettype wire

//--- common/suprloco_pkg.sv
`default_nettype none

package suprloco_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths that carry a meaning
    typedef logic [8:0]  h_count_t;
    typedef logic [8:0]  v_count_t;
    typedef logic [10:0] tmram_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  pixel_t;
    typedef logic [1:0]  pal_code_t;
    typedef logic [4:0]  pal_index_t;
    // 3-3-2 color word, {b[1:0], g[2:0], r[2:0]}
    typedef logic [7:0]  rgb_t;

    typedef enum logic [2:0] {
        FETCH_SCROLL,
        FETCH_CODE_LO,
        FETCH_CODE_HI,
        FETCH_HOST_WRITE,
        FETCH_IDLE
    } fetch_state_t;

    //////////////////////////////////////////////////////////////////////
    // screen timing, in dots and lines
    localparam h_count_t H_TOTAL      = 9'd320;
    localparam h_count_t H_ACTIVE     = 9'd256;
    localparam h_count_t H_SYNC_START = 9'd280;
    localparam h_count_t H_SYNC_LEN   = 9'd32;
    localparam v_count_t V_TOTAL      = 9'd262;
    localparam v_count_t V_ACTIVE     = 9'd224;
    localparam v_count_t V_SYNC_START = 9'd240;
    localparam v_count_t V_SYNC_LEN   = 9'd3;

    // one dot per 8 master clocks
    localparam logic [2:0] PRESCALE_LAST = 3'd7;

    // tile RAM map, row scroll bytes sit above the tile entries
    localparam tmram_addr_t SCROLL_BASE = 11'h7E0;
    // dot at which the next line's scroll byte is read, phase 0 of a group
    localparam h_count_t SCROLL_FETCH_H = 9'd296;

    // counters to output pixel
    localparam int PIPE_DOTS = 16;

endpackage

`default_nettype wire
